// File: include/mdrv_defines.svh
// build-time constants for the multi-drive core: drive count, ROM width, slot and walk sizes
`ifndef MDRV_DEFINES_SVH
`define MDRV_DEFINES_SVH

// number of drive clients sharing the ROM, 1 to 4
`define MDRV_DRIVES 2

// byte address width of one ROM bank image (32K)
`define MDRV_ROM_AW 15

// clock cycles per arbiter frame
`define MDRV_SLOTS 8

// clock enables per frame strobe
`define MDRV_FRAME_DIV 16

// bytes fetched by each client before it stops
`define MDRV_WALK_LEN 64

`endif

// File: verilog/mdrv_pkg.sv
// shared types: ROM address and data, bank and mode, image size, write request, serial lines
`default_nettype none

`include "mdrv_defines.svh"

package mdrv_pkg;

	typedef logic [`MDRV_ROM_AW-1:0] rom_addr_t;
	typedef logic [7:0] rom_data_t;
	typedef logic [1:0] bank_sel_t;

	// drive model, value is the ROM bank it runs from
	typedef enum logic [1:0] {
		MODE_1541 = 2'd0,
		MODE_1570 = 2'd1,
		MODE_1571 = 2'd2,
		MODE_1581 = 2'd3
	} drv_mode_t;

	// code doubles as the mask for address bits 14:13
	typedef enum logic [1:0] {
		SZ_8K  = 2'b00,
		SZ_16K = 2'b01,
		SZ_32K = 2'b11
	} rom_size_t;

	typedef struct packed {
		logic      we;
		bank_sel_t bank;
		rom_addr_t addr;
		rom_data_t data;
	} rom_wr_t;

	// open-collector lines, low means pulled
	typedef struct packed {
		logic data_n;
		logic clk_n;
	} drv_lines_t;

	typedef enum logic [1:0] {IDLE, WALK, DONE} walk_state_t;

endpackage

`default_nettype wire

// File: verilog/mdrv_phase_gen.sv
// frame strobe generator: divides the clock enable and suppresses strobes during pause
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_phase_gen (
	input  wire  clk,
	input  wire  rst_i,
	input  wire  ce_i,
	input  wire  pause_i,
	output logic frame_o
);

	localparam int DIV_W = $clog2(`MDRV_FRAME_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`MDRV_FRAME_DIV - 1);

	logic [DIV_W-1:0] div_q;
	logic             pause_q;

	// ------------------------------------------------------------------------
	// divider keeps running while paused, only the strobe is held back,
	// so frame phase is preserved across a pause
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			div_q   <= '0;
			pause_q <= 1'b0;
			frame_o <= 1'b0;
		end else begin
			pause_q <= pause_i;
			frame_o <= 1'b0;
			if (ce_i) begin
				if (div_q == DIV_LAST) begin
					div_q <= '0;
				end else begin
					div_q <= div_q + 1'b1;
				end
				// one strobe per full turn of the divider
				frame_o <= (div_q == DIV_LAST) && !pause_q;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mdrv_rom_loader.sv
// AXI4-Lite host port: ROM byte writes, per-bank image size tracking and size readback
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_rom_loader (
	input  wire                       clk,
	input  wire                       rst_i,
	// write address and data
	input  wire  [`MDRV_ROM_AW+1:0]   s_awaddr_i,
	input  wire                       s_awvalid_i,
	output logic                      s_awready_o,
	input  wire  [31:0]               s_wdata_i,
	input  wire  [3:0]                s_wstrb_i,
	input  wire                       s_wvalid_i,
	output logic                      s_wready_o,
	output logic [1:0]                s_bresp_o,
	output logic                      s_bvalid_o,
	input  wire                       s_bready_i,
	// size readback
	input  wire  [`MDRV_ROM_AW+1:0]   s_araddr_i,
	input  wire                       s_arvalid_i,
	output logic                      s_arready_o,
	output logic [31:0]               s_rdata_o,
	output logic [1:0]                s_rresp_o,
	output logic                      s_rvalid_o,
	input  wire                       s_rready_i,
	// memory side
	output mdrv_pkg::rom_wr_t         rom_wr_o,
	output mdrv_pkg::rom_size_t       bank_size_o [4]
);

	import mdrv_pkg::*;

	localparam int AW = `MDRV_ROM_AW;

	logic      wr_accept;
	logic      rd_accept;
	bank_sel_t wr_bank;
	bank_sel_t rd_bank;
	logic      size_hit;

	// AW and W taken together, never while a response is outstanding
	assign wr_accept   = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
	assign s_awready_o = wr_accept;
	assign s_wready_o  = wr_accept;
	assign s_bresp_o   = 2'b00;

	assign s_arready_o = !s_rvalid_o;
	assign rd_accept   = s_arvalid_i && s_arready_o;
	assign s_rresp_o   = 2'b00;

	assign wr_bank = s_awaddr_i[AW+1:AW];
	assign rd_bank = s_araddr_i[AW+1:AW];

	assign rom_wr_o.we   = wr_accept && s_wstrb_i[0];
	assign rom_wr_o.bank = wr_bank;
	assign rom_wr_o.addr = s_awaddr_i[AW-1:0];
	assign rom_wr_o.data = s_wdata_i[7:0];

	// filler bytes 00 and FF say nothing about the image size
	assign size_hit = rom_wr_o.we && (|s_wdata_i[7:0]) && !(&s_wdata_i[7:0]);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			s_bvalid_o <= 1'b0;
			s_rvalid_o <= 1'b0;
			for (int b = 0; b < 4; b++) begin
				bank_size_o[b] <= SZ_32K;
			end
		end else begin
			if (wr_accept) begin
				s_bvalid_o <= 1'b1;
			end else if (s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
			if (rd_accept) begin
				s_rvalid_o <= 1'b1;
			end else if (s_rready_i) begin
				s_rvalid_o <= 1'b0;
			end
			if (size_hit) begin
				case (s_awaddr_i[AW-1 -: 2])
					2'b00:   bank_size_o[wr_bank] <= SZ_8K;
					2'b01:   bank_size_o[wr_bank] <= SZ_16K;
					default: bank_size_o[wr_bank] <= SZ_32K;
				endcase
			end
		end
	end

	// read data payload
	always_ff @(posedge clk) begin
		if (rd_accept) begin
			s_rdata_o <= 32'(bank_size_o[rd_bank]);
		end
	end

endmodule

`default_nettype wire

// File: verilog/mdrv_rom_bank.sv
// four-bank ROM byte store with a host write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_rom_bank (
	input  wire                  clk,
	input  mdrv_pkg::rom_wr_t    rom_wr_i,
	input  mdrv_pkg::bank_sel_t  rd_bank_i,
	input  mdrv_pkg::rom_addr_t  rd_addr_i,
	output mdrv_pkg::rom_data_t  rd_data_o
);

	import mdrv_pkg::*;

	localparam int DEPTH = 2 ** `MDRV_ROM_AW;

	// one 32K image per drive model
	rom_data_t mem [4][DEPTH];

	// ------------------------------------------------------------------------
	// host write
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rom_wr_i.we) begin
			mem[rom_wr_i.bank][rom_wr_i.addr] <= rom_wr_i.data;
		end
	end

	// ------------------------------------------------------------------------
	// arbiter read, one cycle latency
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		rd_data_o <= mem[rd_bank_i][rd_addr_i];
	end

endmodule

`default_nettype wire

// File: verilog/mdrv_rom_arbiter.sv
// time-slotted ROM arbiter: size-masks each drive's address and returns its byte with a strobe
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_rom_arbiter (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       frame_i,
	input  mdrv_pkg::drv_mode_t       drv_mode_i [`MDRV_DRIVES],
	input  mdrv_pkg::rom_addr_t       drv_addr_i [`MDRV_DRIVES],
	input  mdrv_pkg::rom_size_t       bank_size_i [4],
	output mdrv_pkg::bank_sel_t       rd_bank_o,
	output mdrv_pkg::rom_addr_t       rd_addr_o,
	input  mdrv_pkg::rom_data_t       rd_data_i,
	output mdrv_pkg::rom_data_t       drv_data_o,
	output logic [`MDRV_DRIVES-1:0]   drv_valid_o
);

	import mdrv_pkg::*;

	localparam int NDR    = `MDRV_DRIVES;
	localparam int AW     = `MDRV_ROM_AW;
	localparam int SLOT_W = $clog2(`MDRV_SLOTS);
	localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(`MDRV_SLOTS - 1);

	logic [SLOT_W-1:0] slot_q;
	logic [SLOT_W-1:0] cyc;
	rom_addr_t         masked [NDR];

	// ------------------------------------------------------------------------
	// frame cycle counter
	// cyc is 0 in the strobe cycle, parks at the last slot until the next frame
	// ------------------------------------------------------------------------
	assign cyc = frame_i ? '0 : slot_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			slot_q <= SLOT_LAST;
		end else if (frame_i) begin
			slot_q <= SLOT_W'(1);
		end else if (slot_q != SLOT_LAST) begin
			slot_q <= slot_q + 1'b1;
		end
	end

	// size code masks the two top address bits of the selected bank
	always_comb begin
		for (int i = 0; i < NDR; i++) begin
			masked[i] = drv_addr_i[i];
			masked[i][AW-1 -: 2] = drv_addr_i[i][AW-1 -: 2] & bank_size_i[drv_mode_i[i]];
		end
	end

	// ------------------------------------------------------------------------
	// request in slot i, memory read in i+1, byte out to drive i in i+3
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		for (int i = 0; i < NDR; i++) begin
			if (cyc == SLOT_W'(i)) begin
				rd_addr_o <= masked[i];
				rd_bank_o <= bank_sel_t'(drv_mode_i[i]);
			end
			if (cyc == SLOT_W'(i + 2)) begin
				drv_data_o <= rd_data_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			drv_valid_o <= '0;
		end else begin
			for (int i = 0; i < NDR; i++) begin
				drv_valid_o[i] <= (cyc == SLOT_W'(i + 2));
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mdrv_drive_client.sv
// drive client: walks its ROM image, keeps a checksum, drives the LED and serial lines
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_drive_client (
	input  wire                  clk,
	input  wire                  rst_i,
	input  wire                  frame_i,
	output mdrv_pkg::rom_addr_t  rom_addr_o,
	input  mdrv_pkg::rom_data_t  rom_data_i,
	input  wire                  rom_valid_i,
	output mdrv_pkg::rom_data_t  checksum_o,
	output logic                 led_o,
	output mdrv_pkg::drv_lines_t lines_o
);

	import mdrv_pkg::*;

	localparam rom_addr_t LAST_ADDR = rom_addr_t'(`MDRV_WALK_LEN - 1);

	walk_state_t state_q;

	// ------------------------------------------------------------------------
	// walk FSM
	// address 0 is already presented while idle, so the first frame fetches it
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q    <= IDLE;
			rom_addr_o <= '0;
			checksum_o <= '0;
			lines_o    <= '1;
		end else begin
			case (state_q)
				IDLE: begin
					if (frame_i) begin
						state_q <= WALK;
					end
				end
				WALK: begin
					if (rom_valid_i) begin
						checksum_o     <= checksum_o + rom_data_i;
						rom_addr_o     <= rom_addr_o + 1'b1;
						lines_o.data_n <= rom_data_i[0];
						lines_o.clk_n  <= rom_data_i[1];
						if (rom_addr_o == LAST_ADDR) begin
							state_q <= DONE;
						end
					end
				end
				// stays here until reset
				default: begin
					state_q <= DONE;
				end
			endcase
		end
	end

	// busy indicator
	assign led_o = (state_q == WALK);

endmodule

`default_nettype wire

// File: verilog/mdrv_bus_combine.sv
// serial bus combiner: wired-AND of drive lines with reset release, LED masking
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_bus_combine (
	input  wire  [`MDRV_DRIVES-1:0]   drv_rst_i,
	input  mdrv_pkg::drv_lines_t      lines_i [`MDRV_DRIVES],
	input  wire  [`MDRV_DRIVES-1:0]   led_i,
	output logic                      iec_data_o,
	output logic                      iec_clk_o,
	output logic [`MDRV_DRIVES-1:0]   led_o
);

	// a drive in reset lets its lines float high
	always_comb begin
		iec_data_o = 1'b1;
		iec_clk_o  = 1'b1;
		for (int i = 0; i < `MDRV_DRIVES; i++) begin
			iec_data_o = iec_data_o & (lines_i[i].data_n | drv_rst_i[i]);
			iec_clk_o  = iec_clk_o & (lines_i[i].clk_n | drv_rst_i[i]);
		end
	end

	assign led_o = led_i & ~drv_rst_i;

endmodule

`default_nettype wire

// File: verilog/mdrv_top.sv
// top level: host loader, ROM banks, arbiter, phase generator, drive clients and bus combiner
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_top (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       ce_i,
	input  wire                       pause_i,
	input  wire  [`MDRV_DRIVES-1:0]   drv_rst_i,
	input  mdrv_pkg::drv_mode_t       drv_mode_i [`MDRV_DRIVES],
	input  wire  [`MDRV_ROM_AW+1:0]   s_awaddr_i,
	input  wire                       s_awvalid_i,
	output logic                      s_awready_o,
	input  wire  [31:0]               s_wdata_i,
	input  wire  [3:0]                s_wstrb_i,
	input  wire                       s_wvalid_i,
	output logic                      s_wready_o,
	output logic [1:0]                s_bresp_o,
	output logic                      s_bvalid_o,
	input  wire                       s_bready_i,
	input  wire  [`MDRV_ROM_AW+1:0]   s_araddr_i,
	input  wire                       s_arvalid_i,
	output logic                      s_arready_o,
	output logic [31:0]               s_rdata_o,
	output logic [1:0]                s_rresp_o,
	output logic                      s_rvalid_o,
	input  wire                       s_rready_i,
	output mdrv_pkg::rom_data_t       checksum_o [`MDRV_DRIVES],
	output logic [`MDRV_DRIVES-1:0]   led_o,
	output logic                      iec_data_o,
	output logic                      iec_clk_o
);

	import mdrv_pkg::*;

	localparam int NDR = `MDRV_DRIVES;

	logic             frame;
	rom_wr_t          rom_wr;
	rom_size_t        bank_size [4];
	bank_sel_t        rd_bank;
	rom_addr_t        rd_addr;
	rom_data_t        rd_data;
	rom_data_t        drv_data;
	logic [NDR-1:0]   drv_valid;
	rom_addr_t        drv_addr [NDR];
	drv_lines_t       drv_lines [NDR];
	logic [NDR-1:0]   drv_led;
	logic [NDR-1:0]   drv_reset;

	assign drv_reset = drv_rst_i | {NDR{rst_i}};

	mdrv_phase_gen u_phase (
		.clk(clk), .rst_i(rst_i), .ce_i(ce_i), .pause_i(pause_i), .frame_o(frame)
	);

	mdrv_rom_loader u_loader (
		.clk(clk), .rst_i(rst_i),
		.s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o), .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o),
		.s_bready_i(s_bready_i), .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i),
		.s_arready_o(s_arready_o), .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
		.s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
		.rom_wr_o(rom_wr), .bank_size_o(bank_size)
	);

	mdrv_rom_bank u_rom (
		.clk(clk), .rom_wr_i(rom_wr), .rd_bank_i(rd_bank), .rd_addr_i(rd_addr),
		.rd_data_o(rd_data)
	);

	mdrv_rom_arbiter u_arb (
		.clk(clk), .rst_i(rst_i), .frame_i(frame), .drv_mode_i(drv_mode_i),
		.drv_addr_i(drv_addr), .bank_size_i(bank_size), .rd_bank_o(rd_bank),
		.rd_addr_o(rd_addr), .rd_data_i(rd_data), .drv_data_o(drv_data),
		.drv_valid_o(drv_valid)
	);

	// one client per drive, each with its own reset
	for (genvar i = 0; i < NDR; i++) begin : g_drive
		mdrv_drive_client u_client (
			.clk(clk), .rst_i(drv_reset[i]), .frame_i(frame),
			.rom_addr_o(drv_addr[i]), .rom_data_i(drv_data), .rom_valid_i(drv_valid[i]),
			.checksum_o(checksum_o[i]), .led_o(drv_led[i]), .lines_o(drv_lines[i])
		);
	end

	mdrv_bus_combine u_bus (
		.drv_rst_i(drv_reset), .lines_i(drv_lines), .led_i(drv_led),
		.iec_data_o(iec_data_o), .iec_clk_o(iec_clk_o), .led_o(led_o)
	);

endmodule

`default_nettype wire

// File: include/mdrv_tb_checks.svh
// testbench compare tasks and the reference model of ROM bytes, image sizes and checksums
`ifndef MDRV_TB_CHECKS_SVH
`define MDRV_TB_CHECKS_SVH

// reference copy of the four banks and their detected sizes
rom_data_t model_rom [4][2**`MDRV_ROM_AW];
rom_size_t model_size [4];

// ------------------------------------------------------------------------
// compare tasks
// ------------------------------------------------------------------------
task automatic check_size(input string name, input rom_size_t got, input rom_size_t exp);
	if (got !== exp) begin
		abort_run($sformatf("[FAIL] time %0t: %s got %s (%b) expected %s (%b)",
			$time, name, got.name(), got, exp.name(), exp));
	end
endtask

task automatic check_sum(input string name, input rom_data_t got, input rom_data_t exp);
	if (got !== exp) begin
		abort_run($sformatf("[FAIL] time %0t: %s got %02h expected %02h",
			$time, name, got, exp));
	end
endtask

task automatic check_line(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("[FAIL] time %0t: %s got %b expected %b",
			$time, name, got, exp));
	end
endtask

// AXI response code
task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
	if (got !== exp) begin
		abort_run($sformatf("[FAIL] time %0t: %s got %02b expected %02b",
			$time, name, got, exp));
	end
endtask

// ------------------------------------------------------------------------
// reference model
// ------------------------------------------------------------------------
// a byte other than 00 or FF sets the size from its 8K region
function automatic void model_write(bank_sel_t bank, rom_addr_t addr, rom_data_t data);
	model_rom[bank][addr] = data;
	if (data != 8'h00 && data != 8'hff) begin
		case (addr[`MDRV_ROM_AW-1 -: 2])
			2'b00:   model_size[bank] = SZ_8K;
			2'b01:   model_size[bank] = SZ_16K;
			default: model_size[bank] = SZ_32K;
		endcase
	end
endfunction

// 8K images wrap every 8K, 16K images every 16K
function automatic rom_addr_t model_addr(rom_size_t size, rom_addr_t addr);
	rom_addr_t a;
	a = addr;
	if (size == SZ_8K) begin
		a[`MDRV_ROM_AW-1] = 1'b0;
		a[`MDRV_ROM_AW-2] = 1'b0;
	end else if (size == SZ_16K) begin
		a[`MDRV_ROM_AW-1] = 1'b0;
	end
	return a;
endfunction

function automatic rom_data_t model_byte(drv_mode_t mode, int k);
	bank_sel_t bank;
	bank = bank_sel_t'(mode);
	return model_rom[bank][model_addr(model_size[bank], rom_addr_t'(k))];
endfunction

// modulo 256 sum of one full walk
function automatic rom_data_t model_sum(drv_mode_t mode);
	rom_data_t sum;
	sum = '0;
	for (int k = 0; k < `MDRV_WALK_LEN; k++) begin
		sum = sum + model_byte(mode, k);
	end
	return sum;
endfunction

`endif

// File: verif/mdrv_tb.sv
// testbench for the multi-drive core: clock, reset, AXI loads, walk schedule, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "mdrv_defines.svh"

module mdrv_tb;

	import mdrv_pkg::*;

	localparam int NDR     = `MDRV_DRIVES;
	localparam int AW      = `MDRV_ROM_AW;
	localparam int WALK    = `MDRV_WALK_LEN;
	localparam int N_RAND  = 64;
	localparam int N_LOADS = 4 * WALK + N_RAND;
	// loads, three walks (paused, interrupted, full) and margin
	localparam int WATCHDOG_CYCLES = N_LOADS * 8 + 3 * WALK * `MDRV_FRAME_DIV * 2 + 1000;

	logic            clk = 1'b0;
	logic            rst;
	logic            ce = 1'b0;
	logic            pause;
	logic [NDR-1:0]  drv_rst;
	drv_mode_t       drv_mode [NDR];
	logic [AW+1:0]   s_awaddr;
	logic            s_awvalid;
	logic            s_awready;
	logic [31:0]     s_wdata;
	logic [3:0]      s_wstrb;
	logic            s_wvalid;
	logic            s_wready;
	logic [1:0]      s_bresp;
	logic            s_bvalid;
	logic            s_bready;
	logic [AW+1:0]   s_araddr;
	logic            s_arvalid;
	logic            s_arready;
	logic [31:0]     s_rdata;
	logic [1:0]      s_rresp;
	logic            s_rvalid;
	logic            s_rready;
	rom_data_t       checksum [NDR];
	logic [NDR-1:0]  led;
	logic            iec_data;
	logic            iec_clk;
	int              b_count = 0;
	int              n_writes = 0;

	mdrv_top DUT (
		.clk(clk), .rst_i(rst), .ce_i(ce), .pause_i(pause), .drv_rst_i(drv_rst),
		.drv_mode_i(drv_mode),
		.s_awaddr_i(s_awaddr), .s_awvalid_i(s_awvalid), .s_awready_o(s_awready),
		.s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb), .s_wvalid_i(s_wvalid),
		.s_wready_o(s_wready), .s_bresp_o(s_bresp), .s_bvalid_o(s_bvalid),
		.s_bready_i(s_bready), .s_araddr_i(s_araddr), .s_arvalid_i(s_arvalid),
		.s_arready_o(s_arready), .s_rdata_o(s_rdata), .s_rresp_o(s_rresp),
		.s_rvalid_o(s_rvalid), .s_rready_i(s_rready),
		.checksum_o(checksum), .led_o(led), .iec_data_o(iec_data), .iec_clk_o(iec_clk)
	);

	always #5 clk = ~clk;

	// clock enable at roughly 75% density
	always @(posedge clk) begin
		ce <= ($urandom_range(3) != 0);
	end

	// count completed write responses
	always @(negedge clk) begin
		if (!rst && s_bvalid && s_bready) begin
			b_count <= b_count + 1;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped on the first error");
	endtask

	`include "mdrv_tb_checks.svh"

	// ------------------------------------------------------------------------
	// host port
	// ------------------------------------------------------------------------
	function automatic rom_data_t random_byte();
		case ($urandom_range(7))
			0:       return 8'h00;
			1:       return 8'hff;
			default: return rom_data_t'($urandom);
		endcase
	endfunction

	task automatic axi_write(input bank_sel_t bank, input rom_addr_t addr, input rom_data_t data);
		int delay;
		delay = $urandom_range(3);
		@(posedge clk);
		s_awaddr  <= {bank, addr};
		s_wdata   <= {24'($urandom), data};
		s_wstrb   <= 4'h1;
		s_awvalid <= 1'b1;
		s_wvalid  <= 1'b1;
		@(negedge clk);
		while (!s_awready) @(negedge clk);
		// address and data are taken in the same cycle
		check_line("s_wready_o", s_wready, 1'b1);
		@(posedge clk);
		s_awvalid <= 1'b0;
		s_wvalid  <= 1'b0;
		model_write(bank, addr, data);
		n_writes++;
		// random response back-pressure
		repeat (delay) @(posedge clk);
		s_bready <= 1'b1;
		@(negedge clk);
		while (!s_bvalid) @(negedge clk);
		check_resp("s_bresp_o", s_bresp, 2'b00);
		@(posedge clk);
		s_bready <= 1'b0;
	endtask

	task automatic read_size(input bank_sel_t bank, output rom_size_t size);
		@(posedge clk);
		s_araddr  <= {bank, AW'(0)};
		s_arvalid <= 1'b1;
		@(negedge clk);
		while (!s_arready) @(negedge clk);
		@(posedge clk);
		s_arvalid <= 1'b0;
		s_rready  <= 1'b1;
		@(negedge clk);
		while (!s_rvalid) @(negedge clk);
		check_resp("s_rresp_o", s_rresp, 2'b00);
		size = rom_size_t'(s_rdata[1:0]);
		@(posedge clk);
		s_rready <= 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// walk results
	// ------------------------------------------------------------------------
	task automatic check_sums();
		for (int i = 0; i < NDR; i++) begin
			check_sum($sformatf("checksum_o[%0d]", i), checksum[i], model_sum(drv_mode[i]));
		end
	endtask

	// bus is the AND of each free drive's last byte, bit 0 data and bit 1 clock
	task automatic check_bus(input logic [NDR-1:0] held_mask);
		logic      exp_data;
		logic      exp_clk;
		rom_data_t last;
		exp_data = 1'b1;
		exp_clk  = 1'b1;
		for (int i = 0; i < NDR; i++) begin
			if (!held_mask[i]) begin
				last     = model_byte(drv_mode[i], WALK - 1);
				exp_data = exp_data & last[0];
				exp_clk  = exp_clk & last[1];
			end
		end
		check_line("iec_data_o", iec_data, exp_data);
		check_line("iec_clk_o", iec_clk, exp_clk);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * 10);
		abort_run($sformatf("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES));
	end

	initial begin
		rom_size_t      size;
		bank_sel_t      bank;
		rom_addr_t      addr;
		logic [1:0]     region;
		int             held;
		logic [NDR-1:0] held_mask;
		rom_data_t      snap [NDR];
		void'($urandom(19));
		rst       = 1'b1;
		pause     = 1'b0;
		drv_rst   = '0;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		for (int i = 0; i < NDR; i++) begin
			drv_mode[i] = drv_mode_t'($urandom_range(3));
		end
		// two drives on one bank
		if (NDR > 1) begin
			drv_mode[NDR-1] = drv_mode[0];
		end
		for (int b = 0; b < 4; b++) begin
			model_size[b] = SZ_32K;
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_line("s_bvalid_o", s_bvalid, 1'b0);
		check_line("s_rvalid_o", s_rvalid, 1'b0);
		check_line("led_o", |led, 1'b0);
		check_line("iec_data_o", iec_data, 1'b1);
		check_line("iec_clk_o", iec_clk, 1'b1);
		// drives stay off the ROM while it loads
		@(posedge clk);
		drv_rst <= '1;

		// ------------------------------------------------------------------------
		// load the walked bytes, then scattered writes over every 8K region
		// ------------------------------------------------------------------------
		for (int b = 0; b < 4; b++) begin
			for (int k = 0; k < WALK; k++) begin
				axi_write(bank_sel_t'(b), rom_addr_t'(k), random_byte());
			end
		end
		for (int n = 0; n < N_RAND; n++) begin
			if (n < 16) begin
				bank   = bank_sel_t'(n / 4);
				region = 2'(n % 4);
			end else begin
				bank   = bank_sel_t'($urandom_range(3));
				region = 2'($urandom_range(3));
			end
			addr = rom_addr_t'($urandom_range(2 ** (AW - 2) - 1));
			addr[AW-1 -: 2] = region;
			axi_write(bank, addr, random_byte());
		end
		@(negedge clk);
		if (b_count != n_writes) begin
			abort_run($sformatf("%0d writes were sent but %0d write responses arrived",
				n_writes, b_count));
		end
		check_line("s_bvalid_o", s_bvalid, 1'b0);
		for (int b = 0; b < 4; b++) begin
			read_size(bank_sel_t'(b), size);
			check_size($sformatf("bank %0d size", b), size, model_size[b]);
		end

		// ------------------------------------------------------------------------
		// first walk with a pause in the middle
		// ------------------------------------------------------------------------
		@(posedge clk);
		drv_rst <= '0;
		@(negedge clk);
		while (led !== '1) @(negedge clk);
		repeat ($urandom_range(200, 50)) @(posedge clk);
		pause <= 1'b1;
		// let a strobe already in flight finish its fetches
		repeat (16) @(posedge clk);
		@(negedge clk);
		for (int i = 0; i < NDR; i++) begin
			snap[i] = checksum[i];
		end
		repeat (200) begin
			@(negedge clk);
			for (int i = 0; i < NDR; i++) begin
				check_line($sformatf("led_o[%0d]", i), led[i], 1'b1);
				check_sum($sformatf("checksum_o[%0d]", i), checksum[i], snap[i]);
			end
		end
		@(posedge clk);
		pause <= 1'b0;
		@(negedge clk);
		while (led !== '0) @(negedge clk);
		check_sums();
		check_bus('0);

		// ------------------------------------------------------------------------
		// one drive held in reset, then interrupted and rerun on a new bank
		// ------------------------------------------------------------------------
		held      = $urandom_range(NDR - 1);
		held_mask = '0;
		held_mask[held] = 1'b1;
		@(posedge clk);
		drv_rst[held]  <= 1'b1;
		drv_mode[held] <= drv_mode_t'($urandom_range(3));
		@(negedge clk);
		check_line("led_o[held]", led[held], 1'b0);
		check_bus(held_mask);
		repeat (20) @(posedge clk);
		drv_rst[held] <= 1'b0;
		@(negedge clk);
		while (!led[held]) @(negedge clk);
		repeat ($urandom_range(100, 20)) @(posedge clk);
		drv_rst[held] <= 1'b1;
		@(negedge clk);
		check_line("led_o[held]", led[held], 1'b0);
		check_bus(held_mask);
		repeat (10) @(posedge clk);
		drv_rst[held] <= 1'b0;
		@(negedge clk);
		while (!led[held]) @(negedge clk);
		while (led[held]) @(negedge clk);
		check_sums();
		check_bus('0);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
verilog/mdrv_pkg.sv
verilog/mdrv_phase_gen.sv
verilog/mdrv_rom_loader.sv
verilog/mdrv_rom_bank.sv
verilog/mdrv_rom_arbiter.sv
verilog/mdrv_drive_client.sv
verilog/mdrv_bus_combine.sv
verilog/mdrv_top.sv
verif/mdrv_tb.sv

// File: Makefile
# Verilator build and run of the multi-drive controller testbench

VERILATOR ?= verilator
TOP       ?= mdrv_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# the simulator exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
